// ==== logic/bridge_pkg.sv ====
package bridge_pkg;

  typedef logic [7:0] byte_t;

  // Host frame terminator
  localparam byte_t HOST_END_0 = 8'hBE;
  localparam byte_t HOST_END_1 = 8'hEF;

  localparam byte_t BLE_END = 8'h0D; // CR closes every BLE line

  // Receive poll sent to the BLE module
  localparam int POLL_LEN = 13;
  localparam byte_t poll_string [POLL_LEN] = '{
    "A", "T", "+", "B", "L", "E", "U", "A", "R", "T", "R", "X", 8'h0D
  };

  localparam int REPLY_BYTES = 5; // Valid reply length without CR

  // Host response codes
  localparam byte_t STATUS_OK   = 8'h06;
  localparam byte_t STATUS_FAIL = 8'h15;
  localparam byte_t ERROR_CODE  = 8'hEE;

  typedef enum logic {
    END_BE_EF,
    END_CR
  } end_mode_e;

  // BLE reply with the first received byte in bits 39:32
  typedef union packed {
    byte_t [REPLY_BYTES-1:0] raw;
    struct packed {
      logic        ok;
      logic [30:0] data;
      byte_t       cmd;
    } fields;
  } reply_word_u;

  typedef enum logic [3:0] {
    S_IDLE, S_FWD_BYTE, S_FWD_HI, S_FWD_LO,
    S_POLL_BYTE, S_POLL_HI, S_POLL_LO, S_WAIT_REPLY,
    S_REPLY_CHECK, S_REPLY_LOAD, S_RESP_BYTE, S_RESP_HI, S_RESP_LO
  } ctrl_state_e;

endpackage

// ==== logic/frame_if.sv ====
interface frame_if #(
  parameter int MAX_FRAME_BYTES = 16
);
  import bridge_pkg::*;

  // One spare count for a held BE at a full store
  localparam int CNT_W = $clog2(MAX_FRAME_BYTES + 2);

  logic             done;     // Level until clear
  logic             error;    // Level until clear
  logic [CNT_W-1:0] size;
  byte_t            rd_data;  // Combinational from rd_index
  logic [CNT_W-1:0] rd_index;
  logic             clear;    // One-cycle pulse

  modport acc (output done, error, size, rd_data, input rd_index, clear);
  modport ctrl (input done, error, size, rd_data, output rd_index, clear);

endinterface

// ==== logic/baud_tick_gen.sv ====
module baud_tick_gen #(
  parameter int CLKS_PER_BIT = 5208
) (
  input  logic clk,
  input  logic reset,
  output logic tick
);

  localparam int CW = $clog2(CLKS_PER_BIT);
  localparam logic [CW-1:0] CNT_LAST = CW'(CLKS_PER_BIT - 1);

  logic [CW-1:0] cnt;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      cnt  <= '0;
      tick <= 1'b0;
    end else if (cnt == CNT_LAST) begin
      cnt  <= '0;
      tick <= 1'b1; // One cycle per bit period
    end else begin
      cnt  <= cnt + 1'b1;
      tick <= 1'b0;
    end
  end

endmodule

// ==== logic/uart_rx.sv ====
module uart_rx #(
  parameter int CLKS_PER_BIT = 5208
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              rx,
  output bridge_pkg::byte_t data,
  output logic              valid
);
  import bridge_pkg::*;

  localparam int CW = $clog2(CLKS_PER_BIT);
  localparam logic [CW-1:0] BIT_LAST  = CW'(CLKS_PER_BIT - 1);
  localparam logic [CW-1:0] HALF_LAST = CW'(CLKS_PER_BIT / 2 - 1);

  localparam logic [1:0] RX_IDLE  = 2'd0;
  localparam logic [1:0] RX_START = 2'd1;
  localparam logic [1:0] RX_DATA  = 2'd2;
  localparam logic [1:0] RX_STOP  = 2'd3;

  logic [2:0]    rx_sync;  // Two sync flops and one for the edge
  logic [1:0]    rx_state;
  logic [CW-1:0] clk_cnt;
  logic [2:0]    bit_cnt;
  logic          bit_done;
  logic          start_edge;
  byte_t         shreg;

  assign bit_done   = (clk_cnt == BIT_LAST);
  assign start_edge = rx_sync[2] && !rx_sync[1];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rx_sync  <= '1;
      rx_state <= RX_IDLE;
      clk_cnt  <= '0;
      bit_cnt  <= '0;
      valid    <= 1'b0;
    end else begin
      rx_sync <= {rx_sync[1:0], rx};
      valid   <= 1'b0;
      case (rx_state)
        RX_IDLE: begin
          clk_cnt <= '0;
          if (start_edge) rx_state <= RX_START;
        end
        RX_START: begin
          if (clk_cnt == HALF_LAST) begin
            clk_cnt  <= '0;
            bit_cnt  <= '0;
            // Glitch shorter than half a bit goes back to idle
            rx_state <= rx_sync[1] ? RX_IDLE : RX_DATA;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        RX_DATA: begin
          if (bit_done) begin
            clk_cnt <= '0;
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) rx_state <= RX_STOP;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: begin
          if (bit_done) begin
            valid    <= rx_sync[1]; // Framing error drops the byte
            rx_state <= RX_IDLE;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rx_state == RX_DATA && bit_done) shreg <= {rx_sync[1], shreg[7:1]}; // LSB first
    if (rx_state == RX_STOP && bit_done) data <= shreg;
  end

endmodule

// ==== logic/uart_tx.sv ====
module uart_tx (
  input  logic              clk,
  input  logic              reset,
  input  logic              tick,
  input  bridge_pkg::byte_t data,
  input  logic              start,
  output logic              tx,
  output logic              busy
);

  logic [9:0] frame_sr; // Stop, data, start
  logic [3:0] bit_cnt;
  logic       load;
  logic       shift;

  assign load  = start && !busy;
  assign shift = tick && busy && (bit_cnt != 4'd10);

  always_ff @(posedge clk) begin
    if (load) begin
      frame_sr <= {1'b1, data, 1'b0};
    end else if (shift) begin
      frame_sr <= {1'b1, frame_sr[9:1]};
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      tx      <= 1'b1; // Line idles high
      busy    <= 1'b0;
      bit_cnt <= '0;
    end else if (load) begin
      busy    <= 1'b1;
      bit_cnt <= '0;
    end else if (tick && busy) begin
      if (bit_cnt == 4'd10) begin
        busy <= 1'b0; // Stop bit has lasted a full period
      end else begin
        tx      <= frame_sr[0];
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

endmodule

// ==== logic/frame_accumulator.sv ====
module frame_accumulator #(
  parameter int                    MAX_FRAME_BYTES = 16,
  parameter bridge_pkg::end_mode_e END_MODE        = bridge_pkg::END_CR
) (
  input  logic              clk,
  input  logic              reset,
  input  bridge_pkg::byte_t data,
  input  logic              valid,
  frame_if.acc              frame
);
  import bridge_pkg::*;

  localparam int CNT_W = $clog2(MAX_FRAME_BYTES + 2);
  localparam logic [CNT_W-1:0] FULL = CNT_W'(MAX_FRAME_BYTES);

  // Extra slot holds a BE that may still turn out to be data
  byte_t            mem [MAX_FRAME_BYTES+1];
  logic [CNT_W-1:0] count;
  logic             pend_be;  // Last stored byte was a BE
  logic             done;
  logic             error;
  logic             accept;
  logic             is_be;
  logic             is_end;
  logic             overflow;
  logic             wr_en;

  assign accept = valid && !done && !error; // Bytes are lost while a frame waits

  always_comb begin
    is_be = (END_MODE == END_BE_EF) && (data == HOST_END_0);
    if (END_MODE == END_CR) begin
      is_end = (data == BLE_END);
    end else begin
      is_end = pend_be && (data == HOST_END_1);
    end
    overflow = (count > FULL) || (count == FULL && !is_be);
    wr_en    = accept && !is_end && !overflow;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      count   <= '0;
      pend_be <= 1'b0;
      done    <= 1'b0;
      error   <= 1'b0;
    end else if (frame.clear) begin
      count   <= '0;
      pend_be <= 1'b0;
      done    <= 1'b0;
      error   <= 1'b0;
    end else if (accept) begin
      if (is_end) begin
        done    <= 1'b1;
        pend_be <= 1'b0;
        if (END_MODE == END_BE_EF) count <= count - 1'b1; // Drop the held BE
      end else if (overflow) begin
        error <= 1'b1;
      end else begin
        count   <= count + 1'b1;
        pend_be <= is_be;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) mem[count] <= data;
  end

  assign frame.done    = done;
  assign frame.error   = error;
  assign frame.size    = count;
  assign frame.rd_data = mem[frame.rd_index];

endmodule

// ==== logic/bridge_ctrl.sv ====
module bridge_ctrl #(
  parameter int TIMEOUT_CYCLES = 4000000
) (
  input  logic              clk,
  input  logic              reset,
  frame_if.ctrl             host_frame,
  frame_if.ctrl             ble_frame,
  output bridge_pkg::byte_t ble_tx_data,
  output logic              ble_tx_start,
  input  logic              ble_tx_busy,
  output bridge_pkg::byte_t host_tx_data,
  output logic              host_tx_start,
  input  logic              host_tx_busy
);
  import bridge_pkg::*;

  localparam int CNT_W = $bits(host_frame.size);
  localparam int TMO_W = $clog2(TIMEOUT_CYCLES + 1);

  ctrl_state_e      state;
  logic [CNT_W-1:0] frame_idx;  // Read index into either frame
  logic [3:0]       poll_idx;
  logic [2:0]       resp_idx;
  logic             resp_err;
  reply_word_u      reply;
  byte_t            resp_byte;
  logic [TMO_W-1:0] tmo_cnt;
  logic             timed_out;
  logic             polling;
  logic             ble_closed;

  assign host_frame.rd_index = frame_idx;
  assign ble_frame.rd_index  = frame_idx;

  assign timed_out  = (tmo_cnt == TMO_W'(TIMEOUT_CYCLES));
  assign polling    = state inside {S_POLL_BYTE, S_POLL_HI, S_POLL_LO, S_WAIT_REPLY};
  assign ble_closed = ble_frame.done || ble_frame.error;

  // Host response byte from the error frame or the decoded reply
  always_comb begin
    if (resp_err) begin
      case (resp_idx)
        3'd0:    resp_byte = ERROR_CODE;
        3'd1:    resp_byte = HOST_END_0;
        default: resp_byte = HOST_END_1;
      endcase
    end else begin
      case (resp_idx)
        3'd0:    resp_byte = reply.fields.ok ? STATUS_OK : STATUS_FAIL;
        3'd1:    resp_byte = reply.fields.cmd;
        3'd2:    resp_byte = {1'b0, reply.fields.data[30:24]};
        3'd3:    resp_byte = reply.fields.data[23:16];
        3'd4:    resp_byte = reply.fields.data[15:8];
        3'd5:    resp_byte = reply.fields.data[7:0];
        3'd6:    resp_byte = HOST_END_0;
        default: resp_byte = HOST_END_1;
      endcase
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      tmo_cnt <= '0;
    end else if (state == S_IDLE) begin
      tmo_cnt <= '0;
    end else if (polling && !timed_out) begin
      tmo_cnt <= tmo_cnt + 1'b1; // Saturates at the limit
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      S_FWD_BYTE:   ble_tx_data  <= (frame_idx < host_frame.size) ? host_frame.rd_data : BLE_END;
      S_POLL_BYTE:  ble_tx_data  <= poll_string[poll_idx];
      S_REPLY_LOAD: reply.raw    <= {reply.raw[REPLY_BYTES-2:0], ble_frame.rd_data};
      S_RESP_BYTE:  host_tx_data <= resp_byte;
      default: ;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state            <= S_IDLE;
      frame_idx        <= '0;
      poll_idx         <= '0;
      resp_idx         <= '0;
      resp_err         <= 1'b0;
      ble_tx_start     <= 1'b0;
      host_tx_start    <= 1'b0;
      host_frame.clear <= 1'b0;
      ble_frame.clear  <= 1'b0;
    end else begin
      ble_tx_start     <= 1'b0;
      host_tx_start    <= 1'b0;
      host_frame.clear <= 1'b0;
      ble_frame.clear  <= 1'b0;
      case (state)
        S_IDLE: begin
          frame_idx <= '0;
          if (!host_frame.clear) begin // Flags are still up during our own clear
            if (host_frame.error) begin
              host_frame.clear <= 1'b1;
            end else if (host_frame.done) begin
              state <= S_FWD_BYTE;
            end
          end
        end
        S_FWD_BYTE: begin
          ble_tx_start <= 1'b1;
          state        <= S_FWD_HI;
        end
        S_FWD_HI: if (ble_tx_busy) state <= S_FWD_LO;
        S_FWD_LO: begin
          if (!ble_tx_busy) begin
            if (frame_idx == host_frame.size) begin // CR went out
              host_frame.clear <= 1'b1;
              ble_frame.clear  <= 1'b1;
              poll_idx         <= '0;
              state            <= S_POLL_BYTE;
            end else begin
              frame_idx <= frame_idx + 1'b1;
              state     <= S_FWD_BYTE;
            end
          end
        end
        S_POLL_BYTE: begin
          ble_tx_start <= 1'b1;
          state        <= S_POLL_HI;
        end
        S_POLL_HI: if (ble_tx_busy) state <= S_POLL_LO;
        S_POLL_LO: begin
          if (!ble_tx_busy) begin
            if (poll_idx != 4'(POLL_LEN - 1)) begin
              poll_idx <= poll_idx + 1'b1;
              state    <= S_POLL_BYTE;
            end else if (ble_closed) begin
              state <= S_REPLY_CHECK;
            end else if (ble_frame.size != '0) begin
              state <= S_WAIT_REPLY; // Reply under way so polling stops
            end else if (timed_out) begin
              resp_err <= 1'b1;
              resp_idx <= '0;
              state    <= S_RESP_BYTE;
            end else begin
              poll_idx <= '0;
              state    <= S_POLL_BYTE;
            end
          end
        end
        S_WAIT_REPLY: begin
          if (ble_closed) begin
            state <= S_REPLY_CHECK;
          end else if (timed_out) begin
            resp_err <= 1'b1;
            resp_idx <= '0;
            state    <= S_RESP_BYTE;
          end
        end
        S_REPLY_CHECK: begin
          frame_idx <= '0;
          resp_idx  <= '0;
          if (ble_frame.error || ble_frame.size != CNT_W'(REPLY_BYTES)) begin
            resp_err <= 1'b1;
            state    <= S_RESP_BYTE;
          end else begin
            resp_err <= 1'b0;
            state    <= S_REPLY_LOAD;
          end
        end
        S_REPLY_LOAD: begin
          frame_idx <= frame_idx + 1'b1;
          if (frame_idx == CNT_W'(REPLY_BYTES - 1)) state <= S_RESP_BYTE;
        end
        S_RESP_BYTE: begin
          host_tx_start <= 1'b1;
          state         <= S_RESP_HI;
        end
        S_RESP_HI: if (host_tx_busy) state <= S_RESP_LO;
        S_RESP_LO: begin
          if (!host_tx_busy) begin
            if (resp_idx == (resp_err ? 3'd2 : 3'd7)) begin
              ble_frame.clear <= 1'b1;
              state           <= S_IDLE;
            end else begin
              resp_idx <= resp_idx + 1'b1;
              state    <= S_RESP_BYTE;
            end
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

// ==== logic/bridge_top.sv ====
module bridge_top #(
  parameter int CLKS_PER_BIT    = 5208,
  parameter int MAX_FRAME_BYTES = 16,
  parameter int TIMEOUT_CYCLES  = 4000000
) (
  input  logic clk,
  input  logic reset,
  input  logic host_uart_rx,
  input  logic ble_uart_rx,
  output logic host_uart_tx,
  output logic ble_uart_tx
);
  import bridge_pkg::*;

  logic  bit_tick;
  byte_t host_rx_data;
  logic  host_rx_valid;
  byte_t ble_rx_data;
  logic  ble_rx_valid;
  byte_t ble_tx_data;
  logic  ble_tx_start;
  logic  ble_tx_busy;
  byte_t host_tx_data;
  logic  host_tx_start;
  logic  host_tx_busy;

  frame_if #(.MAX_FRAME_BYTES(MAX_FRAME_BYTES)) host_frame ();
  frame_if #(.MAX_FRAME_BYTES(MAX_FRAME_BYTES)) ble_frame ();

  baud_tick_gen #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tick (
    .clk(clk), .reset(reset), .tick(bit_tick)
  );

  // Host side serial
  uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_host_rx (
    .clk(clk), .reset(reset), .rx(host_uart_rx), .data(host_rx_data), .valid(host_rx_valid)
  );

  uart_tx u_host_tx (
    .clk(clk), .reset(reset), .tick(bit_tick), .data(host_tx_data),
    .start(host_tx_start), .tx(host_uart_tx), .busy(host_tx_busy)
  );

  // BLE side serial
  uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_ble_rx (
    .clk(clk), .reset(reset), .rx(ble_uart_rx), .data(ble_rx_data), .valid(ble_rx_valid)
  );

  uart_tx u_ble_tx (
    .clk(clk), .reset(reset), .tick(bit_tick), .data(ble_tx_data),
    .start(ble_tx_start), .tx(ble_uart_tx), .busy(ble_tx_busy)
  );

  frame_accumulator #(.MAX_FRAME_BYTES(MAX_FRAME_BYTES), .END_MODE(END_BE_EF)) u_host_acc (
    .clk(clk), .reset(reset), .data(host_rx_data), .valid(host_rx_valid), .frame(host_frame)
  );

  frame_accumulator #(.MAX_FRAME_BYTES(MAX_FRAME_BYTES), .END_MODE(END_CR)) u_ble_acc (
    .clk(clk), .reset(reset), .data(ble_rx_data), .valid(ble_rx_valid), .frame(ble_frame)
  );

  bridge_ctrl #(.TIMEOUT_CYCLES(TIMEOUT_CYCLES)) u_ctrl (
    .clk          (clk),
    .reset        (reset),
    .host_frame   (host_frame),
    .ble_frame    (ble_frame),
    .ble_tx_data  (ble_tx_data),
    .ble_tx_start (ble_tx_start),
    .ble_tx_busy  (ble_tx_busy),
    .host_tx_data (host_tx_data),
    .host_tx_start(host_tx_start),
    .host_tx_busy (host_tx_busy)
  );

endmodule

// ==== verif/bridge_tb_uart.svh ====
`ifndef BRIDGE_TB_UART_SVH
`define BRIDGE_TB_UART_SVH

  // Side select 0 is the host line, 1 the BLE line
  function automatic logic tx_line(input bit ble);
    return ble ? ble_uart_tx : host_uart_tx;
  endfunction

  task automatic drive_rx(input bit ble, input logic level);
    if (ble)
      ble_uart_rx = level;
    else
      host_uart_rx = level;
  endtask

  // Sends one 8N1 frame starting on a falling edge
  task automatic send_byte(input bit ble, input byte_t b);
    int i;
    drive_rx(ble, 1'b0);
    repeat (BIT_CLKS) @(negedge clk);
    for (i = 0; i < 8; i++) begin
      drive_rx(ble, b[i]); // LSB first
      repeat (BIT_CLKS) @(negedge clk);
    end
    drive_rx(ble, 1'b1);
    repeat (BIT_CLKS) @(negedge clk);
  endtask

  // Returns at the middle of the stop bit
  task automatic receive_byte(input bit ble, output byte_t b, output bit got);
    int waited;
    int i;
    waited = 0;
    got = 1'b0;
    b = '0;
    while (tx_line(ble) !== 1'b0 && waited < RX_WAIT_BITS * BIT_CLKS) begin
      @(negedge clk);
      waited++;
    end
    if (tx_line(ble) !== 1'b0) begin
      $display("No byte arrived on %s within %0d bit times at %0t",
               ble ? "ble_uart_tx" : "host_uart_tx", RX_WAIT_BITS, $time);
      errors++;
    end else begin
      repeat (BIT_CLKS / 2) @(negedge clk); // Middle of the start bit
      for (i = 0; i < 8; i++) begin
        repeat (BIT_CLKS) @(negedge clk);
        b[i] = tx_line(ble);
      end
      repeat (BIT_CLKS) @(negedge clk);
      got = (tx_line(ble) === 1'b1);
      if (!got) begin
        $display("Stop bit low on %s at %0t", ble ? "ble_uart_tx" : "host_uart_tx", $time);
        errors++;
      end
    end
  endtask

  // BLE module model that takes the forwarded line and the first poll and then replies
  task automatic respond_ble();
    byte_t b;
    bit    got;
    int    i;
    @(host_frame_sent);
    for (i = 0; i <= payload_len; i++) begin
      receive_byte(1'b1, b, got);
      check_equal((i < payload_len) ? payload[i] : BLE_END, b,
                  $sformatf("forwarded byte %0d", i));
    end
    for (i = 0; i < POLL_LEN; i++) begin
      receive_byte(1'b1, b, got);
      check_equal(poll_string[i], b, $sformatf("first poll byte %0d", i));
    end
    -> first_poll_seen;
    for (i = 0; i < reply_len; i++) begin
      send_byte(1'b1, reply_bytes[i]);
    end
  endtask

`endif

// ==== verif/bridge_tb.sv ====
module bridge_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import bridge_pkg::*;

  localparam int BIT_CLKS       = 16;
  localparam int MAX_BYTES      = 16;
  localparam int TIMEOUT_CYCLES = 20000;
  localparam int RX_WAIT_BITS   = 40;
  localparam int MAX_CYCLES     = 10 * 2 * TIMEOUT_CYCLES; // Six tests under 40000 cycles each

  logic clk;
  logic reset;
  logic host_uart_rx;
  logic ble_uart_rx;
  logic host_uart_tx;
  logic ble_uart_tx;

  int    errors;
  int    cycles = 0;
  byte_t payload [MAX_BYTES+1];
  int    payload_len;
  byte_t reply_bytes [8];
  int    reply_len;    // Counts its CR and is zero for a silent module
  byte_t exp_resp [8];
  int    exp_resp_len;
  event  host_frame_sent;
  event  first_poll_seen;

  bridge_top #(
    .CLKS_PER_BIT   (BIT_CLKS),
    .MAX_FRAME_BYTES(MAX_BYTES),
    .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
  ) dut (
    .clk         (clk),
    .reset       (reset),
    .host_uart_rx(host_uart_rx),
    .ble_uart_rx (ble_uart_rx),
    .host_uart_tx(host_uart_tx),
    .ble_uart_tx (ble_uart_tx)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Run stopped at the limit of %0d cycles before the tests finished", MAX_CYCLES);
      $display(">>> FAIL");
      $finish;
    end
  end

  task automatic check_equal(input logic [31:0] expected, input logic [31:0] actual,
                             input string what);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: %s, expected %0h got %0h", $time, what, expected, actual);
      errors++;
    end
  endtask

  `include "bridge_tb_uart.svh"

  function automatic byte_t random_byte(input byte_t avoid);
    byte_t b;
    b = byte_t'($urandom);
    if (b == avoid) b = b ^ 8'h01;
    return b;
  endfunction

  task automatic make_payload(input int len);
    int i;
    for (i = 0; i < len; i++) begin
      payload[i] = random_byte(HOST_END_0); // No BE, so no early terminator
    end
    payload_len = len;
  endtask

  task automatic make_reply(input int len);
    int i;
    for (i = 0; i < len; i++) begin
      reply_bytes[i] = random_byte(BLE_END);
    end
    reply_bytes[len] = BLE_END;
    reply_len = len + 1;
  endtask

  // Bit 39 gives the status and the fifth reply byte the cmd
  task automatic expect_decoded_reply();
    exp_resp[0] = reply_bytes[0][7] ? STATUS_OK : STATUS_FAIL;
    exp_resp[1] = reply_bytes[4];
    exp_resp[2] = reply_bytes[0] & 8'h7F; // Data bits 30:24 with a zero on top
    exp_resp[3] = reply_bytes[1];
    exp_resp[4] = reply_bytes[2];
    exp_resp[5] = reply_bytes[3];
    exp_resp[6] = HOST_END_0;
    exp_resp[7] = HOST_END_1;
    exp_resp_len = 8;
  endtask

  task automatic expect_error_reply();
    exp_resp[0] = ERROR_CODE;
    exp_resp[1] = HOST_END_0;
    exp_resp[2] = HOST_END_1;
    exp_resp_len = 3;
  endtask

  task automatic send_host_frame();
    int i;
    for (i = 0; i < payload_len; i++) begin
      send_byte(1'b0, payload[i]);
    end
    send_byte(1'b0, HOST_END_0);
    send_byte(1'b0, HOST_END_1);
    -> host_frame_sent;
  endtask

  // Repeated polls until the host response starts
  task automatic watch_polls(input int limit_cycles);
    int    waited;
    int    n;
    byte_t b;
    bit    got;
    waited = 0;
    n = 0;
    while (host_uart_tx === 1'b1 && waited < limit_cycles) begin
      if (ble_uart_tx === 1'b0) begin
        receive_byte(1'b1, b, got);
        check_equal(poll_string[n % POLL_LEN], b, $sformatf("repeated poll byte %0d", n));
        n++;
        waited += 10 * BIT_CLKS;
      end else begin
        @(negedge clk);
        waited++;
      end
    end
    if (host_uart_tx !== 1'b0) begin
      $display("No host response within %0d cycles after the first poll", limit_cycles);
      errors++;
    end
    check_equal(0, n % POLL_LEN, "bytes left over from an unfinished poll");
  endtask

  task automatic run_exchange();
    byte_t b;
    bit    got;
    int    i;
    fork
      send_host_frame();
      respond_ble();
      begin
        @(first_poll_seen);
        watch_polls(2 * TIMEOUT_CYCLES);
      end
    join
    for (i = 0; i < exp_resp_len; i++) begin
      receive_byte(1'b0, b, got);
      check_equal(exp_resp[i], b, $sformatf("host response byte %0d", i));
    end
  endtask

  task automatic test_forwarding();
    make_payload(1 + int'($urandom % MAX_BYTES));
    make_reply(REPLY_BYTES);
    expect_decoded_reply();
    run_exchange();
  endtask

  task automatic test_success_reply();
    make_payload(MAX_BYTES); // Full store
    make_reply(REPLY_BYTES);
    reply_bytes[0] = reply_bytes[0] | 8'h80;
    expect_decoded_reply();
    run_exchange();
  endtask

  task automatic test_failure_status();
    make_payload(1 + int'($urandom % MAX_BYTES));
    make_reply(REPLY_BYTES);
    reply_bytes[0] = reply_bytes[0] & 8'h7F;
    if (reply_bytes[0] == BLE_END) reply_bytes[0] = 8'h0C;
    expect_decoded_reply();
    run_exchange();
  endtask

  task automatic test_timeout();
    make_payload(1 + int'($urandom % MAX_BYTES));
    reply_len = 0; // Module stays silent
    expect_error_reply();
    run_exchange();
  endtask

  task automatic test_wrong_length();
    make_payload(1 + int'($urandom % MAX_BYTES));
    make_reply(3);
    expect_error_reply();
    run_exchange();
  endtask

  task automatic test_overflow();
    int i;
    int busy_cycles;
    make_payload(MAX_BYTES + 1);
    for (i = 0; i < payload_len; i++) begin
      send_byte(1'b0, payload[i]);
    end
    busy_cycles = 0;
    for (i = 0; i < RX_WAIT_BITS * BIT_CLKS; i++) begin
      @(negedge clk);
      if (ble_uart_tx !== 1'b1) busy_cycles++;
    end
    check_equal(0, busy_cycles, "BLE line activity after host overflow");
    test_forwarding();
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    host_uart_rx = 1'b1; // Idle lines
    ble_uart_rx = 1'b1;
    errors = 0;
    $timeformat(-9, 0, " ns", 0);
    void'($urandom(32'h9b7a));
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    repeat (4) @(negedge clk);
    test_forwarding();
    test_success_reply();
    test_failure_status();
    test_timeout();
    test_wrong_length();
    test_overflow();
    $display("Finished 6 tests with %0d errors after %0d cycles", errors, cycles);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+verif
logic/bridge_pkg.sv
logic/frame_if.sv
logic/baud_tick_gen.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/frame_accumulator.sv
logic/bridge_ctrl.sv
logic/bridge_top.sv
verif/bridge_tb.sv
